//--- common/mem_bus_pkg.sv
package mem_bus_pkg;

localparam int DATA_W = 32;
localparam int ADDR_W = 32;
localparam int TAG_W  = 4;

typedef logic [DATA_W-1:0]   data_t;
typedef logic [ADDR_W-1:0]   addr_t;
typedef logic [DATA_W/8-1:0] byte_en_t;
typedef logic [TAG_W-1:0]    tag_t;
typedef logic [TAG_W:0]      bus_tag_t;  // top bit carries the master index

typedef enum logic {
  CMD_RD,
  CMD_WR
} mem_cmd_t;

// ======================================================================
// address map
// ======================================================================
localparam addr_t RAM_BASE  = 32'h0000_0000;
localparam addr_t RAM_SIZE  = 32'h0000_0400;
localparam int    RAM_WORDS = int'(RAM_SIZE) / (DATA_W/8);
localparam int    RAM_IDX_W = $clog2(RAM_WORDS);

localparam addr_t DEV_BASE       = 32'h5400_0000;
localparam addr_t DEV_SIZE       = 32'h0000_1000;
localparam addr_t DEV_STATUS_OFS = 32'h0000_0004;
localparam data_t DEV_STATUS_VAL = 32'h0000_2000;  // transmitter empty, lane 1

// ======================================================================
// read latencies, counted from the accept cycle
// ======================================================================
localparam int RAM_RD_LAT = 2;
localparam int DEV_RD_LAT = 11;
localparam int RSV_DEPTH  = DEV_RD_LAT;  // longest read sets the window

endpackage

//--- common/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if;

import mem_bus_pkg::*;

logic     valid;    // one-cycle strobe per accepted request
mem_cmd_t cmd;
addr_t    addr;
bus_tag_t tag;
data_t    wdata;
byte_en_t byte_en;

modport master (
  output valid,
  output cmd,
  output addr,
  output tag,
  output wdata,
  output byte_en
);

modport target (
  input valid,
  input cmd,
  input addr,
  input tag,
  input wdata,
  input byte_en
);

endinterface

//--- design/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_req_valid   [2],
  input  mem_bus_pkg::mem_cmd_t i_req_cmd     [2],
  input  mem_bus_pkg::addr_t    i_req_addr    [2],
  input  mem_bus_pkg::tag_t     i_req_tag     [2],
  input  mem_bus_pkg::data_t    i_req_wdata   [2],
  input  mem_bus_pkg::byte_en_t i_req_byte_en [2],
  output logic                  o_req_ready   [2],
  mem_req_if.master             ram_bus,
  mem_req_if.master             dev_bus,
  input  logic                  i_ram_resp_valid,
  input  mem_bus_pkg::bus_tag_t i_ram_resp_tag,
  input  mem_bus_pkg::data_t    i_ram_resp_data,
  input  logic                  i_dev_resp_valid,
  input  mem_bus_pkg::bus_tag_t i_dev_resp_tag,
  input  mem_bus_pkg::data_t    i_dev_resp_data,
  output logic                  o_resp_valid  [2],
  output mem_bus_pkg::tag_t     o_resp_tag    [2],
  output mem_bus_pkg::data_t    o_resp_data   [2]
);

import mem_bus_pkg::*;

logic [1:0]           w_is_ram;
logic [1:0]           w_is_dev;
logic [1:0]           w_rsv_hit;
logic [1:0]           w_elig;
logic [1:0]           w_grant;
logic                 w_sel;
logic [RSV_DEPTH-1:0] w_mark;
logic [RSV_DEPTH-1:0] r_rsv;  // bit k set means a response returns k+1 cycles out
logic                 r_ready_en;
logic                 r_last_grant;
logic                 r_ram_valid;
logic                 r_dev_valid;
mem_cmd_t             r_cmd;
addr_t                r_addr;
bus_tag_t             r_tag;
data_t                r_wdata;
byte_en_t             r_byte_en;
bus_tag_t             w_resp_tag;
data_t                w_resp_data;

// ======================================================================
// decode, reservation check and round-robin grant
// ======================================================================
always_comb begin
  for (int m = 0; m < 2; m++) begin
    w_is_ram[m]  = (i_req_addr[m] - RAM_BASE) < RAM_SIZE;
    w_is_dev[m]  = (i_req_addr[m] - DEV_BASE) < DEV_SIZE;
    w_rsv_hit[m] = (i_req_cmd[m] == CMD_RD) &&
                   ((w_is_ram[m] && r_rsv[RAM_RD_LAT-1]) ||
                    (w_is_dev[m] && r_rsv[DEV_RD_LAT-1]));
    w_elig[m]    = r_ready_en && i_req_valid[m] && !w_rsv_hit[m];
  end
end

// the master that lost last time wins a tie
assign w_grant[0] = w_elig[0] && (!w_elig[1] || r_last_grant);
assign w_grant[1] = w_elig[1] && (!w_elig[0] || !r_last_grant);
assign w_sel      = w_grant[1];

assign o_req_ready[0] = w_grant[0];
assign o_req_ready[1] = w_grant[1];

always_comb begin
  w_mark = '0;
  if ((w_grant != 2'b00) && (i_req_cmd[w_sel] == CMD_RD)) begin
    if (w_is_ram[w_sel]) begin
      w_mark[RAM_RD_LAT-1] = 1'b1;
    end else if (w_is_dev[w_sel]) begin
      w_mark[DEV_RD_LAT-1] = 1'b1;
    end
  end
end

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_ready_en   <= 1'b0;
    r_last_grant <= 1'b0;
    r_rsv        <= '0;
    r_ram_valid  <= 1'b0;
    r_dev_valid  <= 1'b0;
  end else begin
    r_ready_en  <= 1'b1;
    r_rsv       <= (r_rsv | w_mark) >> 1;
    r_ram_valid <= (w_grant != 2'b00) && w_is_ram[w_sel];
    r_dev_valid <= (w_grant != 2'b00) && w_is_dev[w_sel];  // unmapped goes nowhere
    if (w_grant != 2'b00) begin
      r_last_grant <= w_sel;
    end
  end
end

always_ff @(posedge i_clk) begin
  if (w_grant != 2'b00) begin
    r_cmd     <= i_req_cmd[w_sel];
    r_addr    <= i_req_addr[w_sel];
    r_tag     <= {w_sel, i_req_tag[w_sel]};
    r_wdata   <= i_req_wdata[w_sel];
    r_byte_en <= i_req_byte_en[w_sel];
  end
end

assign ram_bus.valid   = r_ram_valid;
assign ram_bus.cmd     = r_cmd;
assign ram_bus.addr    = r_addr;
assign ram_bus.tag     = r_tag;
assign ram_bus.wdata   = r_wdata;
assign ram_bus.byte_en = r_byte_en;

assign dev_bus.valid   = r_dev_valid;
assign dev_bus.cmd     = r_cmd;
assign dev_bus.addr    = r_addr;
assign dev_bus.tag     = r_tag;
assign dev_bus.wdata   = r_wdata;
assign dev_bus.byte_en = r_byte_en;

// ======================================================================
// response merge and steering
// ======================================================================
assign w_resp_tag  = i_ram_resp_valid ? i_ram_resp_tag  : i_dev_resp_tag;
assign w_resp_data = i_ram_resp_valid ? i_ram_resp_data : i_dev_resp_data;

always_comb begin
  for (int m = 0; m < 2; m++) begin
    o_resp_valid[m] = (i_ram_resp_valid || i_dev_resp_valid) &&
                      (w_resp_tag[TAG_W] == 1'(m));
    o_resp_tag[m]   = w_resp_tag[TAG_W-1:0];
    o_resp_data[m]  = w_resp_data;
  end
end

// reservation must keep the two targets from ever answering together
a_single_resp: assert property (@(posedge i_clk) disable iff (!i_reset_n)
  !(i_ram_resp_valid && i_dev_resp_valid));

a_single_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
  $onehot0({o_req_ready[1], o_req_ready[0]}));

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/100ps

module scratch_ram (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  mem_req_if.target             bus,
  output logic                  o_resp_valid,
  output mem_bus_pkg::bus_tag_t o_resp_tag,
  output mem_bus_pkg::data_t    o_resp_data
);

import mem_bus_pkg::*;

data_t                r_mem [RAM_WORDS];
addr_t                w_ofs;
logic [RAM_IDX_W-1:0] w_idx;
logic                 w_rd;
logic                 w_wr;

logic                 r_rd_valid [RAM_RD_LAT-1];
bus_tag_t             r_rd_tag   [RAM_RD_LAT-1];
data_t                r_rd_data  [RAM_RD_LAT-1];

assign w_ofs = bus.addr - RAM_BASE;
assign w_idx = w_ofs[RAM_IDX_W+1:2];  // byte address down to word index
assign w_rd  = bus.valid && (bus.cmd == CMD_RD);
assign w_wr  = bus.valid && (bus.cmd == CMD_WR);

always_ff @(posedge i_clk) begin
  if (w_wr) begin
    for (int b = 0; b < DATA_W/8; b++) begin
      if (bus.byte_en[b]) begin
        r_mem[w_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
      end
    end
  end
end

// ======================================================================
// read pipeline, one entry per stage so reads can overlap
// ======================================================================
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    for (int s = 0; s < RAM_RD_LAT-1; s++) begin
      r_rd_valid[s] <= 1'b0;
    end
  end else begin
    r_rd_valid[0] <= w_rd;
    for (int s = 1; s < RAM_RD_LAT-1; s++) begin
      r_rd_valid[s] <= r_rd_valid[s-1];
    end
  end
end

always_ff @(posedge i_clk) begin
  if (w_rd) begin
    r_rd_tag[0]  <= bus.tag;
    r_rd_data[0] <= r_mem[w_idx];
  end
  for (int s = 1; s < RAM_RD_LAT-1; s++) begin
    r_rd_tag[s]  <= r_rd_tag[s-1];
    r_rd_data[s] <= r_rd_data[s-1];
  end
end

assign o_resp_valid = r_rd_valid[RAM_RD_LAT-2];
assign o_resp_tag   = r_rd_tag[RAM_RD_LAT-2];
assign o_resp_data  = r_rd_data[RAM_RD_LAT-2];

// masters only issue whole-word accesses to this region
a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
  bus.valid |-> (bus.addr[1:0] == 2'b00));

endmodule

//--- serial_device/serial_device.sv
`timescale 1ns/100ps

module serial_device (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  mem_req_if.target             bus,
  output logic                  o_resp_valid,
  output mem_bus_pkg::bus_tag_t o_resp_tag,
  output mem_bus_pkg::data_t    o_resp_data,
  output logic                  o_tx_valid,
  output logic [7:0]            o_tx_byte
);

import mem_bus_pkg::*;

addr_t    w_ofs;
logic     w_rd;
logic     w_tx_wr;
logic     w_tx_ok;

logic     r_rd_valid [DEV_RD_LAT-1];
bus_tag_t r_rd_tag   [DEV_RD_LAT-1];
data_t    r_rd_data  [DEV_RD_LAT-1];

assign w_ofs   = bus.addr - DEV_BASE;
assign w_rd    = bus.valid && (bus.cmd == CMD_RD);
assign w_tx_wr = bus.valid && (bus.cmd == CMD_WR) && (w_ofs == '0) && bus.byte_en[0];

// printable characters plus LF and CR reach the console
assign w_tx_ok = (bus.wdata[7:0] >= 8'h20) ||
                 (bus.wdata[7:0] == 8'h0a) ||
                 (bus.wdata[7:0] == 8'h0d);

// ======================================================================
// transmit
// ======================================================================
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    o_tx_valid <= 1'b0;
  end else begin
    o_tx_valid <= w_tx_wr && w_tx_ok;  // control bytes are silently dropped
  end
end

always_ff @(posedge i_clk) begin
  if (w_tx_wr) begin
    o_tx_byte <= bus.wdata[7:0];
  end
end

// ======================================================================
// read delay chain
// ======================================================================
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    for (int s = 0; s < DEV_RD_LAT-1; s++) begin
      r_rd_valid[s] <= 1'b0;
    end
  end else begin
    r_rd_valid[0] <= w_rd;
    for (int s = 1; s < DEV_RD_LAT-1; s++) begin
      r_rd_valid[s] <= r_rd_valid[s-1];
    end
  end
end

always_ff @(posedge i_clk) begin
  if (w_rd) begin
    r_rd_tag[0]  <= bus.tag;
    r_rd_data[0] <= (w_ofs == DEV_STATUS_OFS) ? DEV_STATUS_VAL : '0;
  end
  for (int s = 1; s < DEV_RD_LAT-1; s++) begin
    r_rd_tag[s]  <= r_rd_tag[s-1];
    r_rd_data[s] <= r_rd_data[s-1];
  end
end

assign o_resp_valid = r_rd_valid[DEV_RD_LAT-2];
assign o_resp_tag   = r_rd_tag[DEV_RD_LAT-2];
assign o_resp_data  = r_rd_data[DEV_RD_LAT-2];

endmodule

//--- design/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_m0_req_valid,
  input  mem_bus_pkg::mem_cmd_t i_m0_req_cmd,
  input  mem_bus_pkg::addr_t    i_m0_req_addr,
  input  mem_bus_pkg::tag_t     i_m0_req_tag,
  input  mem_bus_pkg::data_t    i_m0_req_wdata,
  input  mem_bus_pkg::byte_en_t i_m0_req_byte_en,
  output logic                  o_m0_req_ready,
  output logic                  o_m0_resp_valid,
  output mem_bus_pkg::tag_t     o_m0_resp_tag,
  output mem_bus_pkg::data_t    o_m0_resp_data,
  input  logic                  i_m1_req_valid,
  input  mem_bus_pkg::mem_cmd_t i_m1_req_cmd,
  input  mem_bus_pkg::addr_t    i_m1_req_addr,
  input  mem_bus_pkg::tag_t     i_m1_req_tag,
  input  mem_bus_pkg::data_t    i_m1_req_wdata,
  input  mem_bus_pkg::byte_en_t i_m1_req_byte_en,
  output logic                  o_m1_req_ready,
  output logic                  o_m1_resp_valid,
  output mem_bus_pkg::tag_t     o_m1_resp_tag,
  output mem_bus_pkg::data_t    o_m1_resp_data,
  output logic                  o_tx_valid,
  output logic [7:0]            o_tx_byte
);

import mem_bus_pkg::*;

logic     w_req_valid   [2];
mem_cmd_t w_req_cmd     [2];
addr_t    w_req_addr    [2];
tag_t     w_req_tag     [2];
data_t    w_req_wdata   [2];
byte_en_t w_req_byte_en [2];
logic     w_req_ready   [2];
logic     w_resp_valid  [2];
tag_t     w_resp_tag    [2];
data_t    w_resp_data   [2];

logic     w_ram_resp_valid;
bus_tag_t w_ram_resp_tag;
data_t    w_ram_resp_data;
logic     w_dev_resp_valid;
bus_tag_t w_dev_resp_tag;
data_t    w_dev_resp_data;

// master ports gathered into per-index arrays
assign w_req_valid   = '{i_m0_req_valid, i_m1_req_valid};
assign w_req_cmd     = '{i_m0_req_cmd, i_m1_req_cmd};
assign w_req_addr    = '{i_m0_req_addr, i_m1_req_addr};
assign w_req_tag     = '{i_m0_req_tag, i_m1_req_tag};
assign w_req_wdata   = '{i_m0_req_wdata, i_m1_req_wdata};
assign w_req_byte_en = '{i_m0_req_byte_en, i_m1_req_byte_en};

assign o_m0_req_ready  = w_req_ready[0];
assign o_m0_resp_valid = w_resp_valid[0];
assign o_m0_resp_tag   = w_resp_tag[0];
assign o_m0_resp_data  = w_resp_data[0];
assign o_m1_req_ready  = w_req_ready[1];
assign o_m1_resp_valid = w_resp_valid[1];
assign o_m1_resp_tag   = w_resp_tag[1];
assign o_m1_resp_data  = w_resp_data[1];

mem_req_if ram_bus ();
mem_req_if dev_bus ();

mem_arbiter u_arbiter (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_req_valid      (w_req_valid),
  .i_req_cmd        (w_req_cmd),
  .i_req_addr       (w_req_addr),
  .i_req_tag        (w_req_tag),
  .i_req_wdata      (w_req_wdata),
  .i_req_byte_en    (w_req_byte_en),
  .o_req_ready      (w_req_ready),
  .ram_bus          (ram_bus.master),
  .dev_bus          (dev_bus.master),
  .i_ram_resp_valid (w_ram_resp_valid),
  .i_ram_resp_tag   (w_ram_resp_tag),
  .i_ram_resp_data  (w_ram_resp_data),
  .i_dev_resp_valid (w_dev_resp_valid),
  .i_dev_resp_tag   (w_dev_resp_tag),
  .i_dev_resp_data  (w_dev_resp_data),
  .o_resp_valid     (w_resp_valid),
  .o_resp_tag       (w_resp_tag),
  .o_resp_data      (w_resp_data)
);

scratch_ram u_ram (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .bus          (ram_bus.target),
  .o_resp_valid (w_ram_resp_valid),
  .o_resp_tag   (w_ram_resp_tag),
  .o_resp_data  (w_ram_resp_data)
);

serial_device u_serial (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .bus          (dev_bus.target),
  .o_resp_valid (w_dev_resp_valid),
  .o_resp_tag   (w_dev_resp_tag),
  .o_resp_data  (w_dev_resp_data),
  .o_tx_valid   (o_tx_valid),
  .o_tx_byte    (o_tx_byte)
);

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

localparam int HALF_PERIOD_NS = 4;  // 8 ns clock
localparam int RESET_CYCLES   = 10;

initial begin
  o_clk = 1'b0;
  forever #HALF_PERIOD_NS o_clk = ~o_clk;
end

// reset is released on a rising edge so the first active edge is the next one
initial begin
  o_reset_n = 1'b0;
  repeat (RESET_CYCLES) @(posedge o_clk);
  o_reset_n <= 1'b1;
end

endmodule

//--- dv/tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys;

import mem_bus_pkg::*;

localparam int          MAX_OPS     = 64;
localparam int          OP_WORDS    = 8;
localparam int          WAIT_LIMIT  = 200;
localparam int          RUN_LIMIT   = 4000;
localparam int          RAM_LAT_CYC = 2;   // cycles from accept to response
localparam int          DEV_LAT_CYC = 11;
localparam int          TX_LAT_CYC  = 2;
localparam logic [31:0] END_MARK    = 32'hffff_ffff;
localparam int F_MASTER = 0;
localparam int F_CMD    = 1;
localparam int F_ADDR   = 2;
localparam int F_WDATA  = 3;
localparam int F_BE     = 4;
localparam int F_TAG    = 5;
localparam int F_RDATA  = 6;
localparam int F_TX     = 7;

logic     clk;
logic     reset_n;
logic     m0_req_valid;
mem_cmd_t m0_req_cmd;
addr_t    m0_req_addr;
tag_t     m0_req_tag;
data_t    m0_req_wdata;
byte_en_t m0_req_byte_en;
logic     m0_req_ready;
logic     m0_resp_valid;
tag_t     m0_resp_tag;
data_t    m0_resp_data;
logic     m1_req_valid;
mem_cmd_t m1_req_cmd;
addr_t    m1_req_addr;
tag_t     m1_req_tag;
data_t    m1_req_wdata;
byte_en_t m1_req_byte_en;
logic     m1_req_ready;
logic     m1_resp_valid;
tag_t     m1_resp_tag;
data_t    m1_resp_data;
logic       tx_valid;
logic [7:0] tx_byte;

logic [31:0] td      [MAX_OPS*OP_WORDS];
logic [31:0] ref_ram [256];  // word image of the scratch RAM
logic        pend      [2][16];
logic [31:0] pend_data [2][16];
int          pend_due  [2][16];
logic [31:0] tx_exp_q [$];
int          tx_due_q [$];
int          n_ops;
int          cycle = 0;
int          checks = 0;
int          errors = 0;
logic        drv0_done = 1'b0;
logic        drv1_done = 1'b0;

clk_gen u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

mem_subsys_top dut (
  .i_clk(clk), .i_reset_n(reset_n),
  .i_m0_req_valid(m0_req_valid), .i_m0_req_cmd(m0_req_cmd), .i_m0_req_addr(m0_req_addr),
  .i_m0_req_tag(m0_req_tag), .i_m0_req_wdata(m0_req_wdata), .i_m0_req_byte_en(m0_req_byte_en),
  .o_m0_req_ready(m0_req_ready), .o_m0_resp_valid(m0_resp_valid),
  .o_m0_resp_tag(m0_resp_tag), .o_m0_resp_data(m0_resp_data),
  .i_m1_req_valid(m1_req_valid), .i_m1_req_cmd(m1_req_cmd), .i_m1_req_addr(m1_req_addr),
  .i_m1_req_tag(m1_req_tag), .i_m1_req_wdata(m1_req_wdata), .i_m1_req_byte_en(m1_req_byte_en),
  .o_m1_req_ready(m1_req_ready), .o_m1_resp_valid(m1_resp_valid),
  .o_m1_resp_tag(m1_resp_tag), .o_m1_resp_data(m1_resp_data),
  .o_tx_valid(tx_valid), .o_tx_byte(tx_byte)
);

always @(posedge clk) cycle <= cycle + 1;

function automatic logic [31:0] field(input int op, input int f);
  return td[op*OP_WORDS + f];
endfunction

function automatic mem_cmd_t cmd_of(input int op);
  return (field(op, F_CMD) == 32'd0) ? CMD_RD : CMD_WR;
endfunction

function automatic tag_t tag_of(input int op);
  logic [31:0] v;
  v = field(op, F_TAG);
  return v[3:0];
endfunction

function automatic byte_en_t byte_en_of(input int op);
  logic [31:0] v;
  v = field(op, F_BE);
  return v[3:0];
endfunction

function automatic logic in_ram(input logic [31:0] addr);
  return addr < 32'h0000_0400;
endfunction

function automatic logic in_serial(input logic [31:0] addr);
  return (addr >= 32'h5400_0000) && (addr < 32'h5400_1000);
endfunction

function automatic logic console_ok(input logic [7:0] b);
  return (b >= 8'h20) || (b == 8'h0a) || (b == 8'h0d);
endfunction

function automatic int outstanding();
  int n;
  n = 0;
  for (int m = 0; m < 2; m++) begin
    for (int t = 0; t < 16; t++) n += int'(pend[m][t]);
  end
  return n;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  assert (act === exp) else begin
    errors++;
    $display("FAIL %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic finish_run();
  $display("checks %0d, errors %0d", checks, errors);
  if (errors == 0) begin
    $display("SIMULATION PASSED");
  end else begin
    $display("SIMULATION FAILED");
  end
  $finish;
endtask

// ======================================================================
// test data and the reference model that cross-checks it
// ======================================================================
task automatic load_testdata();
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] be;
  logic [31:0] want;
  int          w;
  for (int i = 0; i < MAX_OPS*OP_WORDS; i++) td[i] = END_MARK;
  for (int m = 0; m < 2; m++) begin
    for (int t = 0; t < 16; t++) pend[m][t] = 1'b0;
  end
  $readmemh("dv/mem_subsys_testdata.txt", td);
  n_ops = 0;
  while (n_ops < MAX_OPS && td[n_ops*OP_WORDS] != END_MARK) n_ops++;
  checks++;
  assert (n_ops > 0) else begin
    errors++;
    $display("ERROR: no operations could be read from the test data file");
  end
  for (int op = 0; op < n_ops; op++) begin
    addr  = field(op, F_ADDR);
    wdata = field(op, F_WDATA);
    be    = field(op, F_BE);
    if (in_ram(addr)) begin
      w = int'(addr[9:2]);
      if (cmd_of(op) == CMD_WR) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) ref_ram[w][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end else begin
        check_value($sformatf("file op %0d ram data", op), ref_ram[w], field(op, F_RDATA));
      end
    end else if (in_serial(addr)) begin
      if (cmd_of(op) == CMD_WR) begin
        want = (addr == 32'h5400_0000 && be[0] && console_ok(wdata[7:0])) ?
               {23'h0, 1'b1, wdata[7:0]} : 32'h0;
        check_value($sformatf("file op %0d tx byte", op), want, field(op, F_TX));
      end else begin
        want = (addr == 32'h5400_0004) ? 32'h0000_2000 : 32'h0;  // transmitter empty
        check_value($sformatf("file op %0d status", op), want, field(op, F_RDATA));
      end
    end
  end
endtask

// ======================================================================
// request drivers
// ======================================================================
task automatic record_accept(input int m, input int op);
  logic [31:0] tx;
  tag_t        tag;
  tx  = field(op, F_TX);
  tag = tag_of(op);
  if (cmd_of(op) == CMD_RD) begin
    pend[m][tag]      = 1'b1;
    pend_data[m][tag] = field(op, F_RDATA);
    pend_due[m][tag]  = cycle + (in_serial(field(op, F_ADDR)) ? DEV_LAT_CYC : RAM_LAT_CYC);
  end else if (tx[8]) begin
    tx_exp_q.push_back({24'h0, tx[7:0]});  // bytes are expected in accept order
    tx_due_q.push_back(cycle + TX_LAT_CYC);
  end
endtask

task automatic wait_accept(input int m, input int op, output logic ok);
  int n;
  n  = 0;
  ok = 1'b0;
  while (!ok && n < WAIT_LIMIT) begin
    @(negedge clk);
    ok = ((m == 0) ? m0_req_ready : m1_req_ready) === 1'b1;
    n++;
  end
  checks++;
  assert (ok) else begin
    errors++;
    $display("ERROR: master %0d request for op %0d was never accepted", m, op);
  end
  if (ok) begin
    record_accept(m, op);
  end
endtask

task automatic wait_reset_release();
  int n;
  n = 0;
  while (reset_n !== 1'b1 && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  checks++;
  assert (reset_n === 1'b1) else begin
    errors++;
    $display("ERROR: reset was never released");
  end
endtask

initial begin : drive_m0
  logic accepted;
  m0_req_valid   <= 1'b0;
  m0_req_cmd     <= CMD_RD;
  m0_req_addr    <= '0;
  m0_req_tag     <= '0;
  m0_req_wdata   <= '0;
  m0_req_byte_en <= '0;
  wait_reset_release();
  for (int op = 0; op < n_ops; op++) begin
    if (field(op, F_MASTER) == 32'd0) begin
      @(posedge clk);
      m0_req_valid   <= 1'b1;
      m0_req_cmd     <= cmd_of(op);
      m0_req_addr    <= field(op, F_ADDR);
      m0_req_tag     <= tag_of(op);
      m0_req_wdata   <= field(op, F_WDATA);
      m0_req_byte_en <= byte_en_of(op);
      wait_accept(0, op, accepted);
      if (!accepted) begin
        break;
      end
    end
  end
  @(posedge clk);
  m0_req_valid <= 1'b0;
  drv0_done = 1'b1;
end

initial begin : drive_m1
  logic accepted;
  m1_req_valid   <= 1'b0;
  m1_req_cmd     <= CMD_RD;
  m1_req_addr    <= '0;
  m1_req_tag     <= '0;
  m1_req_wdata   <= '0;
  m1_req_byte_en <= '0;
  wait_reset_release();
  for (int op = 0; op < n_ops; op++) begin
    if (field(op, F_MASTER) == 32'd1) begin
      @(posedge clk);
      m1_req_valid   <= 1'b1;
      m1_req_cmd     <= cmd_of(op);
      m1_req_addr    <= field(op, F_ADDR);
      m1_req_tag     <= tag_of(op);
      m1_req_wdata   <= field(op, F_WDATA);
      m1_req_byte_en <= byte_en_of(op);
      wait_accept(1, op, accepted);
      if (!accepted) begin
        break;
      end
    end
  end
  @(posedge clk);
  m1_req_valid <= 1'b0;
  drv1_done = 1'b1;
end

// ======================================================================
// response and console monitors, sampled mid-cycle
// ======================================================================
task automatic take_response(input int m, input tag_t tag, input data_t data);
  checks++;
  assert (pend[m][tag]) else begin
    errors++;
    $display("ERROR: master %0d got a response with tag %h that it was not waiting for", m, tag);
  end
  if (pend[m][tag]) begin
    pend[m][tag] = 1'b0;
    check_value($sformatf("m%0d tag %h read data", m, tag), pend_data[m][tag], data);
    check_value($sformatf("m%0d tag %h response cycle", m, tag), pend_due[m][tag], cycle);
  end
endtask

task automatic take_tx(input logic [7:0] b);
  checks++;
  assert (tx_exp_q.size() > 0) else begin
    errors++;
    $display("ERROR: console byte %h was sent while none was expected", b);
  end
  if (tx_exp_q.size() > 0) begin
    check_value("console byte", tx_exp_q.pop_front(), {24'h0, b});
    check_value("console byte cycle", tx_due_q.pop_front(), cycle);
  end
endtask

always @(negedge clk) begin
  checks++;
  assert (!$isunknown({m0_resp_valid, m1_resp_valid, tx_valid})) else begin
    errors++;
    $display("ERROR: a response or console strobe is unknown at cycle %0d", cycle);
  end
  if (!reset_n) begin
    assert ({m0_resp_valid, m1_resp_valid, tx_valid} === 3'b000) else begin
      errors++;
      $display("ERROR: a response or console strobe is active during reset");
    end
  end else begin
    if (m0_resp_valid === 1'b1) take_response(0, m0_resp_tag, m0_resp_data);
    if (m1_resp_valid === 1'b1) take_response(1, m1_resp_tag, m1_resp_data);
    if (tx_valid === 1'b1) take_tx(tx_byte);
  end
end

initial begin : main
  int n;
  load_testdata();
  n = 0;
  while (!(drv0_done && drv1_done) && n < RUN_LIMIT) begin
    @(negedge clk);
    n++;
  end
  checks++;
  assert (drv0_done && drv1_done) else begin
    errors++;
    $display("ERROR: the request drivers did not finish in time");
  end
  n = 0;
  while ((outstanding() > 0 || tx_exp_q.size() > 0) && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  checks++;
  assert (outstanding() == 0 && tx_exp_q.size() == 0) else begin
    errors++;
    $display("ERROR: %0d reads and %0d console bytes never arrived",
             outstanding(), tx_exp_q.size());
  end
  repeat (DEV_LAT_CYC + 2) @(negedge clk);  // late duplicates would show up here
  finish_run();
end

endmodule

//--- dv/mem_subsys_testdata.txt
// master cmd(0 rd, 1 wr) addr wdata byte_en tag exp_rdata tx
// tx is 1HH when byte HH must appear on the console and 0 when nothing may appear
0 1 00000000 11223344 f 0 00000000 000
1 1 00000200 cafef00d f 0 00000000 000
0 1 00000004 55667788 f 1 00000000 000
1 1 00000200 00001234 3 1 00000000 000
0 1 00000000 aabbccdd 5 2 00000000 000
1 0 00000200 00000000 0 2 cafe1234 000
0 1 00000004 eeff0011 c 3 00000000 000
0 0 00000000 00000000 0 4 11bb33dd 000
0 0 00000004 00000000 0 5 eeff7788 000
0 1 54000000 00000048 1 6 00000000 148
1 1 54000000 0000007e 1 3 00000000 17e
0 1 54000000 00000069 1 7 00000000 169
0 1 54000000 00000007 1 8 00000000 000
1 1 54000000 0000001b 1 4 00000000 000
0 1 54000000 0000000d 1 9 00000000 10d
0 1 54000000 0000000a 1 a 00000000 10a
0 1 54000008 00000041 1 b 00000000 000
0 1 54000000 00000041 e c 00000000 000
0 0 54000004 00000000 0 d 00002000 000
1 0 54000004 00000000 0 5 00002000 000
1 0 00000200 00000000 0 6 cafe1234 000
0 0 54000000 00000000 0 e 00000000 000
0 0 00000000 00000000 0 f 11bb33dd 000
1 0 54000010 00000000 0 7 00000000 000
1 0 00000200 00000000 0 8 cafe1234 000

//--- build.f
common/mem_bus_pkg.sv
common/mem_req_if.sv
design/mem_arbiter.sv
design/scratch_ram.sv
serial_device/serial_device.sv
design/mem_subsys_top.sv
dv/clk_gen.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run from the project root, pass only if the testbench says so
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f build.f \
  && ./obj_dir/Vtb_mem_subsys | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "run_sim.sh: pass" \
  || { echo "run_sim.sh: fail"; exit 1; }
